/* compile.f */
+incdir+sim
common/dl_rx_pkg.sv
hw/rx/lcrc32_calc.sv
hw/rx/fc_credit_tracker.sv
hw/rx/rx_frame_fifo.sv
hw/rx/rx_frame_parser.sv
hw/dl_rx_top.sv
sim/tb_dl_rx.sv

/* Makefile */
# Verilator build and run for the data link layer receive testbench

VERILATOR    ?= verilator
TOP          ?= tb_dl_rx
FILELIST     ?= compile.f
OBJ_DIR      ?= obj_dir
LOG          ?= sim.log
VFLAGS       ?= --binary --timing -j 0
PASS_PATTERN ?= *** PASSED ***

SOURCES := $(wildcard common/*.sv hw/*.sv hw/rx/*.sv sim/*.sv sim/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the exit status of the binary
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -qF '$(PASS_PATTERN)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_dl_rx_table.svh */
/*
 * Frame table and reference models for the receive path testbench.
 * Included inside the testbench module, after the package import.
 */
`ifndef TB_DL_RX_TABLE_SVH
`define TB_DL_RX_TABLE_SVH

typedef struct packed {
  logic [SEQ_W-1:0] seq;
  logic [7:0]       fmt_type;
  logic [LEN_W-1:0] len;
  logic [7:0]       n_words;
  logic             corrupt;
  logic             exp_good;
} frame_row_t;

localparam int N_FRAMES = 14;

// seq, fmt/type, length in dwords, TLP words, corrupt LCRC, expected good
localparam frame_row_t FRAME_TAB [N_FRAMES] = '{
  '{12'd0,  TLP_MWR32,      10'd8,  8'd6,  1'b0, 1'b1},
  '{12'd1,  TLP_MWR64,      10'd16, 8'd8,  1'b1, 1'b0},
  '{12'd1,  TLP_MWR32,      10'd2,  8'd5,  1'b0, 1'b1},
  // sequence number from the future
  '{12'd5,  TLP_MRD32,      10'd1,  8'd3,  1'b0, 1'b0},
  '{12'd2,  TLP_MRD64,      10'd4,  8'd4,  1'b0, 1'b1},
  '{12'd3,  TLP_IOWR,       10'd1,  8'd4,  1'b0, 1'b1},
  '{12'd4,  TLP_MSG_LAST,   10'd0,  8'd4,  1'b0, 1'b1},
  '{12'd5,  TLP_CPL,        10'd0,  8'd3,  1'b0, 1'b1},
  '{12'd6,  TLP_CPLD,       10'd12, 8'd12, 1'b0, 1'b1},
  // reserved code, no credit class
  '{12'd7,  8'h1F,          10'd3,  8'd3,  1'b0, 1'b1},
  '{12'd8,  TLP_MSGD_FIRST, 10'd20, 8'd10, 1'b0, 1'b1},
  '{12'd9,  TLP_CAS32,      10'd4,  8'd6,  1'b1, 1'b0},
  '{12'd9,  TLP_FETCHADD64, 10'd2,  8'd6,  1'b0, 1'b1},
  '{12'd10, TLP_CPLDLK,     10'd64, 8'd20, 1'b0, 1'b1}
};

// bytewise reflected crc-32, lsb of each byte first
function automatic logic [31:0] lcrc32_ref(input logic [31:0] words[$]);
  logic [31:0] crc;
  crc = 32'hFFFF_FFFF;
  foreach (words[i]) begin
    for (int b = 0; b < 4; b++) begin
      crc = crc ^ {24'd0, words[i][8*b +: 8]};
      for (int k = 0; k < 8; k++) begin
        crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
    end
  end
  return ~crc;
endfunction

// 0 posted, 1 non-posted, 2 completion, -1 no credit class
function automatic int hdr_group(input logic [7:0] ft);
  int grp;
  case (ft) inside
    TLP_MWR32, TLP_MWR64, [TLP_MSG_FIRST:TLP_MSG_LAST],
    [TLP_MSGD_FIRST:TLP_MSGD_LAST]: grp = 0;
    TLP_MRD32, TLP_MRD64, TLP_MRDLK, TLP_IORD, TLP_CFGRD0, TLP_CFGRD1,
    TLP_IOWR, TLP_CFGWR0, TLP_CFGWR1, TLP_FETCHADD32, TLP_FETCHADD64,
    TLP_SWAP32, TLP_SWAP64, TLP_CAS32, TLP_CAS64: grp = 1;
    TLP_CPL, TLP_CPLLK, TLP_CPLD, TLP_CPLDLK: grp = 2;
    default: grp = -1;
  endcase
  return grp;
endfunction

// one data credit per 4 dwords, never less than one
function automatic logic [11:0] data_units(input logic [LEN_W-1:0] len);
  logic [11:0] units;
  units = {4'd0, len[9:2]};
  if (units == 12'd0) begin
    units = 12'd1;
  end
  return units;
endfunction

// word 0 carries fmt/type and length, the rest is a per-frame pattern
function automatic logic [31:0] tlp_word(input int idx, input int w, input logic [7:0] ft,
                                         input logic [LEN_W-1:0] len);
  logic [31:0] word;
  if (w == 0) begin
    word = {len[7:0], 6'd0, len[9:8], 8'd0, ft};
  end else begin
    word = {idx[7:0], w[7:0], 16'hC35A ^ 16'(idx * 7 + w)};
  end
  return word;
endfunction

function automatic int table_words();
  int total;
  total = 0;
  for (int i = 0; i < N_FRAMES; i++) begin
    total = total + int'(FRAME_TAB[i].n_words) + 2;
  end
  return total;
endfunction

`endif

/* sim/tb_dl_rx.sv */
`timescale 1ns/1ps
/*
 * Testbench for the data link layer receive path. Sends the frame table
 * through the DUT with random output stalls and ack delays, and checks the
 * output stream, credits, sequence number, nullify flag and ack handshake.
 */
module tb_dl_rx import dl_rx_pkg::*; ;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;

  logic                   clk_i;
  logic                   rst_i;
  logic [DATA_W-1:0]      s_data_i;
  logic                   s_valid_i;
  logic                   s_last_i;
  logic                   s_ready_o;
  logic [DATA_W-1:0]      m_data_o;
  logic                   m_valid_o;
  logic                   m_last_o;
  logic                   m_ready_i;
  logic                   ack_req_o;
  logic                   ack_i;
  logic                   tlp_nullified_o;
  logic [SEQ_W-1:0]       next_rx_seq_o;
  logic [HDR_CRED_W-1:0]  ph_credits_o;
  logic [HDR_CRED_W-1:0]  nph_credits_o;
  logic [HDR_CRED_W-1:0]  cplh_credits_o;
  logic [DATA_CRED_W-1:0] pd_credits_o;
  logic [DATA_CRED_W-1:0] npd_credits_o;
  logic [DATA_CRED_W-1:0] cpld_credits_o;

  `include "tb_dl_rx_table.svh"

  int errors = 0;
  int checks = 0;
  int seed = 6;
  int out_idx = 0;
  // expected output words, last flag on top
  logic [32:0]      exp_q[$];
  logic [SEQ_W-1:0] model_seq;
  logic             model_null;
  // index 0 posted, 1 non-posted, 2 completion
  logic [7:0]       hdr_model[3];
  logic [11:0]      data_model[3];

  dl_rx_top dl_rx_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic note_failure(input string msg);
    errors++;
    $display("%s at %0t", msg, $time);
  endtask

  task automatic check_state();
    check_field("next_rx_seq_o", 32'(model_seq), 32'(next_rx_seq_o));
    check_field("tlp_nullified_o", 32'(model_null), 32'(tlp_nullified_o));
    check_field("ph_credits_o", 32'(hdr_model[0]), 32'(ph_credits_o));
    check_field("nph_credits_o", 32'(hdr_model[1]), 32'(nph_credits_o));
    check_field("cplh_credits_o", 32'(hdr_model[2]), 32'(cplh_credits_o));
    check_field("pd_credits_o", 32'(data_model[0]), 32'(pd_credits_o));
    check_field("npd_credits_o", 32'(data_model[1]), 32'(npd_credits_o));
    check_field("cpld_credits_o", 32'(data_model[2]), 32'(cpld_credits_o));
  endtask

  // called 10 ns after an edge, returns 10 ns after the transfer edge
  task automatic send_beat(input logic [31:0] data, input logic last);
    logic taken;
    s_data_i  = data;
    s_valid_i = 1'b1;
    s_last_i  = last;
    taken     = 1'b0;
    while (!taken) begin
      @(negedge clk_i);
      taken = s_ready_o;
      @(posedge clk_i);
      #DRIVE_DLY;
    end
    s_valid_i = 1'b0;
    s_last_i  = 1'b0;
  endtask

  task automatic run_frame(input int idx);
    frame_row_t  row;
    logic [31:0] words[$];
    logic [31:0] lcrc;
    logic        good;
    logic        last_flag;
    int          grp;
    int          waited;
    int          delay;
    row = FRAME_TAB[idx];
    words = {};
    words.push_back({20'd0, row.seq});
    for (int w = 0; w < int'(row.n_words); w++) begin
      words.push_back(tlp_word(idx, w, row.fmt_type, row.len));
    end
    lcrc = lcrc32_ref(words);
    if (row.corrupt) begin
      lcrc = lcrc ^ 32'h0000_0100;
    end
    good = row.exp_good;
    model_null = !good;
    if (good) begin
      for (int w = 1; w <= int'(row.n_words); w++) begin
        last_flag = (w == int'(row.n_words));
        exp_q.push_back({last_flag, words[w]});
      end
      grp = hdr_group(row.fmt_type);
      if (grp >= 0) begin
        hdr_model[grp] = hdr_model[grp] + 8'd1;
        // fmt bit 6 marks a TLP with data
        if (row.fmt_type[6]) begin
          data_model[grp] = data_model[grp] + data_units(row.len);
        end
      end
      model_seq = model_seq + 12'd1;
    end
    for (int b = 0; b < words.size(); b++) begin
      send_beat(words[b], 1'b0);
    end
    send_beat(lcrc, 1'b1);
    @(negedge clk_i);
    if (s_ready_o) begin
      note_failure($sformatf("frame %0d: input still ready after the LCRC beat", idx));
    end
    // verdict one cycle after the LCRC beat, ack request one cycle later
    waited = 0;
    while (!ack_req_o && waited < 8) begin
      @(negedge clk_i);
      waited++;
    end
    if (!ack_req_o) begin
      note_failure($sformatf("frame %0d: ack request never came", idx));
    end else if (waited != 1) begin
      note_failure($sformatf("frame %0d: ack request came %0d cycles late", idx, waited - 1));
    end
    check_state();
    delay = $unsigned($random(seed)) % 32'd6;
    repeat (delay) begin
      @(negedge clk_i);
      if (!ack_req_o || s_ready_o) begin
        note_failure($sformatf("frame %0d: ack wait not held (ack_req %0d, s_ready %0d)",
                               idx, ack_req_o, s_ready_o));
      end
    end
    @(posedge clk_i);
    #DRIVE_DLY;
    ack_i = 1'b1;
    @(posedge clk_i);
    #DRIVE_DLY;
    ack_i = 1'b0;
    @(negedge clk_i);
    if (ack_req_o) begin
      note_failure($sformatf("frame %0d: ack request still high after ack", idx));
    end
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // output sink stalls about one cycle in four
  initial begin
    m_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #DRIVE_DLY;
      m_ready_i = ($random(seed) & 3) != 0;
    end
  end

  initial begin : monitor
    forever begin
      @(negedge clk_i);
      if (!rst_i && m_valid_o && m_ready_i) begin
        if (out_idx >= exp_q.size()) begin
          note_failure($sformatf("output word %h with no good frame pending", m_data_o));
        end else begin
          check_field("m_data_o", exp_q[out_idx][31:0], m_data_o);
          check_field("m_last_o", 32'(exp_q[out_idx][32]), 32'(m_last_o));
          out_idx++;
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    limit = table_words() * 20 + 5;
    repeat (limit) @(posedge clk_i);
    $display("timeout: test did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    rst_i      = 1'b1;
    s_data_i   = '0;
    s_valid_i  = 1'b0;
    s_last_i   = 1'b0;
    ack_i      = 1'b0;
    model_seq  = '0;
    model_null = 1'b0;
    for (int g = 0; g < 3; g++) begin
      hdr_model[g]  = HDR_MIN_CREDITS;
      data_model[g] = DATA_MIN_CREDITS;
    end
    repeat (5) @(posedge clk_i);
    #DRIVE_DLY;
    rst_i = 1'b0;
    @(negedge clk_i);
    check_field("s_ready_o", 32'd1, 32'(s_ready_o));
    check_field("m_valid_o", 32'd0, 32'(m_valid_o));
    check_field("ack_req_o", 32'd0, 32'(ack_req_o));
    check_state();
    @(posedge clk_i);
    #DRIVE_DLY;
    for (int i = 0; i < N_FRAMES; i++) begin
      run_frame(i);
    end
    while (out_idx != exp_q.size()) begin
      @(negedge clk_i);
    end
    repeat (4) begin
      @(negedge clk_i);
      if (m_valid_o) begin
        note_failure("output still valid after all good frames were received");
      end
    end
    $display("frames %0d, output words %0d, checks %0d, errors %0d",
             N_FRAMES, out_idx, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* hw/dl_rx_top.sv */
`timescale 1ns/1ps
/*
 * Receive side of the PCIe data link layer. Takes sequence/TLP/LCRC frames
 * from the PHY, forwards good TLPs to the transaction layer and reports
 * consumed credits, the next expected sequence number and nullified TLPs.
 */
module dl_rx_top import dl_rx_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic [DATA_W-1:0]      s_data_i,
  input  logic                   s_valid_i,
  input  logic                   s_last_i,
  output logic                   s_ready_o,
  output logic [DATA_W-1:0]      m_data_o,
  output logic                   m_valid_o,
  output logic                   m_last_o,
  input  logic                   m_ready_i,
  output logic                   ack_req_o,
  input  logic                   ack_i,
  output logic                   tlp_nullified_o,
  output logic [SEQ_W-1:0]       next_rx_seq_o,
  output logic [HDR_CRED_W-1:0]  ph_credits_o,
  output logic [HDR_CRED_W-1:0]  nph_credits_o,
  output logic [HDR_CRED_W-1:0]  cplh_credits_o,
  output logic [DATA_CRED_W-1:0] pd_credits_o,
  output logic [DATA_CRED_W-1:0] npd_credits_o,
  output logic [DATA_CRED_W-1:0] cpld_credits_o
);

  logic              crc_clear;
  logic              crc_update;
  logic [DATA_W-1:0] crc_value;
  logic              fifo_wr;
  logic [DATA_W-1:0] fifo_data;
  logic              fifo_last;
  logic              fifo_full;
  logic              verdict_stb;
  logic              verdict_good;
  tlp_class_e        tlp_class;
  logic [LEN_W-1:0]  tlp_len;

  rx_frame_parser rx_frame_parser_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .s_data_i        (s_data_i),
    .s_valid_i       (s_valid_i),
    .s_last_i        (s_last_i),
    .s_ready_o       (s_ready_o),
    .ack_i           (ack_i),
    .fifo_full_i     (fifo_full),
    .crc_value_i     (crc_value),
    .crc_clear_o     (crc_clear),
    .crc_update_o    (crc_update),
    .fifo_wr_o       (fifo_wr),
    .fifo_data_o     (fifo_data),
    .fifo_last_o     (fifo_last),
    .verdict_stb_o   (verdict_stb),
    .verdict_good_o  (verdict_good),
    .tlp_class_o     (tlp_class),
    .tlp_len_o       (tlp_len),
    .ack_req_o       (ack_req_o),
    .tlp_nullified_o (tlp_nullified_o),
    .next_rx_seq_o   (next_rx_seq_o)
  );

  // crc runs over the raw input words, the parser decides which ones count
  lcrc32_calc lcrc32_calc_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .clear_i  (crc_clear),
    .update_i (crc_update),
    .data_i   (s_data_i),
    .crc_o    (crc_value)
  );

  fc_credit_tracker fc_credit_tracker_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .verdict_stb_i  (verdict_stb),
    .verdict_good_i (verdict_good),
    .tlp_class_i    (tlp_class),
    .tlp_len_i      (tlp_len),
    .ph_credits_o   (ph_credits_o),
    .nph_credits_o  (nph_credits_o),
    .cplh_credits_o (cplh_credits_o),
    .pd_credits_o   (pd_credits_o),
    .npd_credits_o  (npd_credits_o),
    .cpld_credits_o (cpld_credits_o)
  );

  rx_frame_fifo rx_frame_fifo_i (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .wr_i           (fifo_wr),
    .wr_data_i      (fifo_data),
    .wr_last_i      (fifo_last),
    .full_o         (fifo_full),
    .verdict_stb_i  (verdict_stb),
    .verdict_good_i (verdict_good),
    .m_data_o       (m_data_o),
    .m_valid_o      (m_valid_o),
    .m_last_o       (m_last_o),
    .m_ready_i      (m_ready_i)
  );

endmodule

/* hw/rx/rx_frame_parser.sv */
`timescale 1ns/1ps
/*
 * Frame FSM of the receive path. Captures the sequence word, decodes the
 * TLP header, hands TLP words to the frame FIFO one beat late so the final
 * word carries its last flag, checks LCRC and sequence, then waits for ack.
 */
module rx_frame_parser import dl_rx_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [DATA_W-1:0] s_data_i,
  input  logic              s_valid_i,
  input  logic              s_last_i,
  output logic              s_ready_o,
  input  logic              ack_i,
  input  logic              fifo_full_i,
  input  logic [DATA_W-1:0] crc_value_i,
  output logic              crc_clear_o,
  output logic              crc_update_o,
  output logic              fifo_wr_o,
  output logic [DATA_W-1:0] fifo_data_o,
  output logic              fifo_last_o,
  output logic              verdict_stb_o,
  output logic              verdict_good_o,
  output tlp_class_e        tlp_class_o,
  output logic [LEN_W-1:0]  tlp_len_o,
  output logic              ack_req_o,
  output logic              tlp_nullified_o,
  output logic [SEQ_W-1:0]  next_rx_seq_o
);

  typedef enum logic [1:0] {
    ST_SEQ,
    ST_HDR,
    ST_BODY,
    ST_ACK
  } state_e;

  state_e            state_r;
  logic              accept;
  logic              crc_ok;
  logic              seq_ok;
  logic [7:0]        fmt_type;
  tlp_class_e        hdr_class;
  logic [SEQ_W-1:0]  rx_seq_r;
  logic [SEQ_W-1:0]  exp_seq_r;
  logic [DATA_W-1:0] pend_data_r;
  tlp_class_e        class_r;
  logic [LEN_W-1:0]  len_r;
  logic              verdict_stb_r;
  logic              verdict_good_r;
  logic              ack_req_r;
  logic              nullified_r;

  // input stalls while waiting for ack or when the FIFO has no room
  assign s_ready_o = (state_r != ST_ACK) && !fifo_full_i;
  assign accept    = s_valid_i && s_ready_o;

  // lcrc word itself is never folded in
  assign crc_clear_o  = (state_r == ST_ACK);
  assign crc_update_o = accept && !s_last_i;

  // held word goes out when the next beat shows whether it was the last one
  assign fifo_wr_o   = accept && (state_r == ST_BODY);
  assign fifo_data_o = pend_data_r;
  assign fifo_last_o = s_last_i;

  assign crc_ok = (s_data_i == ~crc_value_i);
  assign seq_ok = (rx_seq_r == exp_seq_r);

  assign fmt_type = s_data_i[7:0];

  always_comb begin
    if (fmt_type inside {TLP_MRD32, TLP_MRD64, TLP_MRDLK, TLP_IORD, TLP_CFGRD0,
                         TLP_CFGRD1}) begin
      hdr_class = CLASS_NPH;
    end else if (fmt_type inside {TLP_MWR32, TLP_MWR64,
                                  [TLP_MSGD_FIRST:TLP_MSGD_LAST]}) begin
      hdr_class = CLASS_PD;
    end else if (fmt_type inside {[TLP_MSG_FIRST:TLP_MSG_LAST]}) begin
      hdr_class = CLASS_PH;
    end else if (fmt_type inside {TLP_IOWR, TLP_CFGWR0, TLP_CFGWR1,
                                  TLP_FETCHADD32, TLP_FETCHADD64, TLP_SWAP32,
                                  TLP_SWAP64, TLP_CAS32, TLP_CAS64}) begin
      hdr_class = CLASS_NPD;
    end else if (fmt_type inside {TLP_CPL, TLP_CPLLK}) begin
      hdr_class = CLASS_CPLH;
    end else if (fmt_type inside {TLP_CPLD, TLP_CPLDLK}) begin
      hdr_class = CLASS_CPLD;
    end else begin
      hdr_class = CLASS_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r       <= ST_SEQ;
      verdict_stb_r <= 1'b0;
      ack_req_r     <= 1'b0;
      exp_seq_r     <= '0;
      nullified_r   <= 1'b0;
    end else begin
      verdict_stb_r <= accept && s_last_i;
      if (accept && s_last_i) begin
        state_r <= ST_ACK;
      end else if (accept && state_r == ST_SEQ) begin
        state_r <= ST_HDR;
      end else if (accept && state_r == ST_HDR) begin
        state_r <= ST_BODY;
      end else if (state_r == ST_ACK && ack_req_r && ack_i) begin
        state_r <= ST_SEQ;
      end
      // request rises after the verdict and drops once acknowledged
      if (verdict_stb_r) begin
        ack_req_r <= 1'b1;
      end else if (ack_i) begin
        ack_req_r <= 1'b0;
      end
      if (verdict_stb_r) begin
        nullified_r <= !verdict_good_r;
        if (verdict_good_r) begin
          exp_seq_r <= exp_seq_r + SEQ_W'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && !s_last_i) begin
      if (state_r == ST_SEQ) begin
        rx_seq_r <= s_data_i[SEQ_W-1:0];
      end
      if (state_r == ST_HDR) begin
        class_r <= hdr_class;
        len_r   <= {s_data_i[17:16], s_data_i[31:24]};
      end
      if (state_r == ST_HDR || state_r == ST_BODY) begin
        pend_data_r <= s_data_i;
      end
    end
    // a frame without TLP words is always bad
    if (accept && s_last_i) begin
      verdict_good_r <= (state_r == ST_BODY) && crc_ok && seq_ok;
    end
  end

  assign verdict_stb_o   = verdict_stb_r;
  assign verdict_good_o  = verdict_good_r;
  assign tlp_class_o     = class_r;
  assign tlp_len_o       = len_r;
  assign ack_req_o       = ack_req_r;
  assign tlp_nullified_o = nullified_r;
  assign next_rx_seq_o   = exp_seq_r;

endmodule

/* hw/rx/rx_frame_fifo.sv */
`timescale 1ns/1ps
/*
 * Frame FIFO between the parser and the transaction layer. Words are
 * written speculatively and only become readable once the verdict commits
 * the frame; a bad verdict rolls the write pointer back and drops the TLP.
 */
module rx_frame_fifo import dl_rx_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              wr_i,
  input  logic [DATA_W-1:0] wr_data_i,
  input  logic              wr_last_i,
  output logic              full_o,
  input  logic              verdict_stb_i,
  input  logic              verdict_good_i,
  output logic [DATA_W-1:0] m_data_o,
  output logic              m_valid_o,
  output logic              m_last_o,
  input  logic              m_ready_i
);

  // last flag is stored above the data word
  logic [DATA_W:0]  mem [FIFO_DEPTH];
  logic [DATA_W:0]  rd_word;
  logic [FIFO_AW:0] wr_ptr_r;
  logic [FIFO_AW:0] commit_ptr_r;
  logic [FIFO_AW:0] rd_ptr_r;
  logic             wr_en;
  logic             rd_en;

  // extra pointer bit tells full from empty
  assign full_o = (wr_ptr_r[FIFO_AW] != rd_ptr_r[FIFO_AW]) &&
                  (wr_ptr_r[FIFO_AW-1:0] == rd_ptr_r[FIFO_AW-1:0]);
  assign wr_en  = wr_i && !full_o;

  // only committed words are visible to the reader
  assign m_valid_o = (rd_ptr_r != commit_ptr_r);
  assign rd_word   = mem[rd_ptr_r[FIFO_AW-1:0]];
  assign m_data_o  = rd_word[DATA_W-1:0];
  assign m_last_o  = rd_word[DATA_W];
  assign rd_en     = m_valid_o && m_ready_i;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem[wr_ptr_r[FIFO_AW-1:0]] <= {wr_last_i, wr_data_i};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r     <= '0;
      commit_ptr_r <= '0;
      rd_ptr_r     <= '0;
    end else begin
      if (verdict_stb_i && !verdict_good_i) begin
        // drop the whole speculative frame
        wr_ptr_r <= commit_ptr_r;
      end else if (wr_en) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (verdict_stb_i && verdict_good_i) begin
        commit_ptr_r <= wr_ptr_r;
      end
      if (rd_en) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

endmodule

/* hw/rx/fc_credit_tracker.sv */
`timescale 1ns/1ps
/*
 * Consumed flow-control credit counters for the six credit types.
 * A good verdict adds one header credit for the TLP's class and, for the
 * data classes, one data credit per four dwords of payload (at least one).
 */
module fc_credit_tracker import dl_rx_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   verdict_stb_i,
  input  logic                   verdict_good_i,
  input  tlp_class_e             tlp_class_i,
  input  logic [LEN_W-1:0]       tlp_len_i,
  output logic [HDR_CRED_W-1:0]  ph_credits_o,
  output logic [HDR_CRED_W-1:0]  nph_credits_o,
  output logic [HDR_CRED_W-1:0]  cplh_credits_o,
  output logic [DATA_CRED_W-1:0] pd_credits_o,
  output logic [DATA_CRED_W-1:0] npd_credits_o,
  output logic [DATA_CRED_W-1:0] cpld_credits_o
);

  logic [LEN_W-3:0]       len_units;
  logic [DATA_CRED_W-1:0] data_inc;

  // payload in 16-byte units, short payloads still use one credit
  assign len_units = tlp_len_i[LEN_W-1:2];
  assign data_inc  = (len_units == '0) ? DATA_CRED_W'(1) : DATA_CRED_W'(len_units);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ph_credits_o   <= HDR_MIN_CREDITS;
      nph_credits_o  <= HDR_MIN_CREDITS;
      cplh_credits_o <= HDR_MIN_CREDITS;
      pd_credits_o   <= DATA_MIN_CREDITS;
      npd_credits_o  <= DATA_MIN_CREDITS;
      cpld_credits_o <= DATA_MIN_CREDITS;
    end else if (verdict_stb_i && verdict_good_i) begin
      case (tlp_class_i)
        CLASS_PH: begin
          ph_credits_o <= ph_credits_o + HDR_CRED_W'(1);
        end
        CLASS_PD: begin
          ph_credits_o <= ph_credits_o + HDR_CRED_W'(1);
          pd_credits_o <= pd_credits_o + data_inc;
        end
        CLASS_NPH: begin
          nph_credits_o <= nph_credits_o + HDR_CRED_W'(1);
        end
        CLASS_NPD: begin
          nph_credits_o <= nph_credits_o + HDR_CRED_W'(1);
          npd_credits_o <= npd_credits_o + data_inc;
        end
        CLASS_CPLH: begin
          cplh_credits_o <= cplh_credits_o + HDR_CRED_W'(1);
        end
        CLASS_CPLD: begin
          cplh_credits_o <= cplh_credits_o + HDR_CRED_W'(1);
          cpld_credits_o <= cpld_credits_o + data_inc;
        end
        // unknown types consume nothing
        default: begin
        end
      endcase
    end
  end

endmodule

/* hw/rx/lcrc32_calc.sv */
`timescale 1ns/1ps
/*
 * Running LCRC accumulator. Folds one 32-bit word per update, least
 * significant byte first, with the reflected CRC-32 polynomial. The
 * parser complements the result before comparing it to the LCRC word.
 */
module lcrc32_calc import dl_rx_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              clear_i,
  input  logic              update_i,
  input  logic [DATA_W-1:0] data_i,
  output logic [DATA_W-1:0] crc_o
);

  logic [DATA_W-1:0] crc_r;
  logic [DATA_W-1:0] crc_next;

  // bit 0 of byte 0 goes in first, so the word is walked from its lsb
  always_comb begin
    crc_next = crc_r;
    for (int i = 0; i < DATA_W; i++) begin
      if (crc_next[0] ^ data_i[i]) begin
        crc_next = (crc_next >> 1) ^ CRC_POLY;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i || clear_i) begin
      crc_r <= CRC_INIT;
    end else if (update_i) begin
      crc_r <= crc_next;
    end
  end

  assign crc_o = crc_r;

endmodule

/* common/dl_rx_pkg.sv */
/*
 * Shared definitions for the data link layer receive path: stream and
 * field widths, FIFO sizing, LCRC constants, TLP fmt/type codes, the credit
 * class enumeration and the consumed-credit reset values.
 */
package dl_rx_pkg;

  // stream and field widths
  localparam int DATA_W      = 32;
  localparam int SEQ_W       = 12;
  localparam int LEN_W       = 10;
  localparam int HDR_CRED_W  = 8;
  localparam int DATA_CRED_W = 12;

  localparam int MAX_PAYLOAD = 256;

  // largest TLP is 4 header dwords plus a full payload
  localparam int MAX_TLP_DW = 4 + MAX_PAYLOAD / 4;
  localparam int FIFO_DEPTH = 1 << $clog2(MAX_TLP_DW);
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // consumed credit counters start from the advertised minimum
  localparam logic [HDR_CRED_W-1:0]  HDR_MIN_CREDITS  = HDR_CRED_W'(1);
  localparam logic [DATA_CRED_W-1:0] DATA_MIN_CREDITS = DATA_CRED_W'(MAX_PAYLOAD / 16);

  // reflected crc-32
  localparam logic [DATA_W-1:0] CRC_INIT = 32'hFFFF_FFFF;
  localparam logic [DATA_W-1:0] CRC_POLY = 32'hEDB8_8320;

  typedef enum logic [2:0] {
    CLASS_NONE,
    CLASS_PH,
    CLASS_PD,
    CLASS_NPH,
    CLASS_NPD,
    CLASS_CPLH,
    CLASS_CPLD
  } tlp_class_e;

  // non-posted requests without data
  localparam logic [7:0] TLP_MRD32  = 8'h00;
  localparam logic [7:0] TLP_MRD64  = 8'h20;
  localparam logic [7:0] TLP_MRDLK  = 8'h01;
  localparam logic [7:0] TLP_IORD   = 8'h02;
  localparam logic [7:0] TLP_CFGRD0 = 8'h04;
  localparam logic [7:0] TLP_CFGRD1 = 8'h05;

  // posted writes and messages
  localparam logic [7:0] TLP_MWR32      = 8'h40;
  localparam logic [7:0] TLP_MWR64      = 8'h60;
  localparam logic [7:0] TLP_MSG_FIRST  = 8'h30;
  localparam logic [7:0] TLP_MSG_LAST   = 8'h37;
  localparam logic [7:0] TLP_MSGD_FIRST = 8'h70;
  localparam logic [7:0] TLP_MSGD_LAST  = 8'h77;

  // non-posted requests with data
  localparam logic [7:0] TLP_IOWR       = 8'h42;
  localparam logic [7:0] TLP_CFGWR0     = 8'h44;
  localparam logic [7:0] TLP_CFGWR1     = 8'h45;
  localparam logic [7:0] TLP_FETCHADD32 = 8'h4C;
  localparam logic [7:0] TLP_FETCHADD64 = 8'h6C;
  localparam logic [7:0] TLP_SWAP32     = 8'h4D;
  localparam logic [7:0] TLP_SWAP64     = 8'h6D;
  localparam logic [7:0] TLP_CAS32      = 8'h4E;
  localparam logic [7:0] TLP_CAS64      = 8'h6E;

  // completions
  localparam logic [7:0] TLP_CPL    = 8'h0A;
  localparam logic [7:0] TLP_CPLLK  = 8'h0B;
  localparam logic [7:0] TLP_CPLD   = 8'h4A;
  localparam logic [7:0] TLP_CPLDLK = 8'h4B;

endpackage
